/* hdl/panel_pkg.sv */
package panel_pkg;

  // highest bit of the lockout counter, the lockout runs for 2**debounce_bits counts
  localparam integer debounce_bits = 4;

  // the panel address is 16 bits wide but only the low byte reaches the memory
  localparam integer addr_width = 16;

  // data, data switches and leds all share this width
  localparam integer data_width = 8;

  // number of bytes in the panel memory
  localparam integer ram_depth = 256;

  // the display selector wraps after the last view
  localparam integer view_count = 6;

  // front panel switch sequencer states
  typedef enum logic [2:0] {
    tr_latch    = 3'd0,
    tr_wait     = 3'd1,
    tr_trig1    = 3'd2,
    tr_trig2    = 3'd3,
    tr_trig3    = 3'd4,
    tr_delay    = 3'd5,
    tr_reenable = 3'd6
  } trig_state_t;

  // commands decoded from one strobe burst, cmd_none when only dsel was pressed
  typedef enum logic [2:0] {
    cmd_none      = 3'd0,
    cmd_clear     = 3'd1,
    cmd_extd_addr = 3'd2,
    cmd_addr_load = 3'd3,
    cmd_dep       = 3'd4,
    cmd_exam      = 3'd5,
    cmd_cont      = 3'd6
  } panel_cmd_t;

  // monitor sequencer states
  typedef enum logic [1:0] {
    mon_idle  = 2'd0,
    mon_read  = 2'd1,
    mon_write = 2'd2
  } mon_state_t;

  // what the eight leds show, picked by dsel
  typedef enum logic [2:0] {
    view_addr_lo  = 3'd0,
    view_addr_hi  = 3'd1,
    view_data     = 3'd2,
    view_switches = 3'd3,
    view_last_cmd = 3'd4,
    view_status   = 3'd5
  } view_t;

endpackage

/* hdl/panel_strobe_if.sv */
`timescale 1ns/10ps

// strobe burst from the switch sequencer to the monitor
// every strobe of a burst rises with triggerd and stays up for several cycles
interface panel_strobe_if;

  logic triggerd;
  logic cleard;
  logic extd_addrd;
  logic addr_loadd;
  logic depd;
  logic examd;
  logic contd;
  logic dseld;
  // high while the panel is locked out after a burst
  logic sw_active;

  // the switch sequencer drives the whole bundle
  modport source (
    output triggerd, cleard, extd_addrd, addr_loadd, depd, examd, contd, dseld,
    output sw_active
  );

  // the monitor only listens
  modport sink (
    input triggerd, cleard, extd_addrd, addr_loadd, depd, examd, contd, dseld,
    input sw_active
  );

endinterface

/* hdl/front_panel.sv */
`timescale 1ns/10ps

module front_panel (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  clear,
  input  logic                  extd_addr,
  input  logic                  addr_load,
  input  logic                  dep,
  input  logic                  exam,
  input  logic                  cont,
  input  logic                  dsel_sw,
  panel_strobe_if.source        strobes,
  output logic [2:0]            dsel
);

  panel_pkg::trig_state_t trig_state;

  // switches seen so far while waiting for a press, in strobe order
  logic [6:0] switch_latch;

  // the burst being presented, trigger in the top bit
  logic [7:0] burst;

  // lockout counter, expiry is its top bit setting
  logic [panel_pkg::debounce_bits:0] trig_cnt;

  logic sw_active_q;

  // the burst register fans out straight onto the strobe bundle
  assign {strobes.triggerd, strobes.cleard, strobes.extd_addrd, strobes.addr_loadd,
          strobes.depd, strobes.examd, strobes.contd, strobes.dseld} = burst;
  assign strobes.sw_active = sw_active_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      trig_state   <= panel_pkg::tr_latch;
      switch_latch <= '0;
      burst        <= '0;
      trig_cnt     <= '0;
      sw_active_q  <= 1'b0;
      dsel         <= '0;
    end else begin
      case (trig_state)
        panel_pkg::tr_latch: begin
          // collect any switch that goes high, a short press still counts
          switch_latch <= switch_latch |
                          {clear, extd_addr, addr_load, dep, exam, cont, dsel_sw};
          // the test looks at the latch from the previous cycle
          // so the set gets one more cycle to pick up switches pressed together
          if (switch_latch != '0) begin
            trig_state <= panel_pkg::tr_wait;
          end
        end
        panel_pkg::tr_wait: begin
          // present the latched set with the trigger and clear the latch
          burst        <= {1'b1, switch_latch};
          switch_latch <= '0;
          trig_state   <= panel_pkg::tr_trig1;
        end
        panel_pkg::tr_trig1: begin
          // the lockout count starts from zero for every burst
          trig_cnt   <= '0;
          trig_state <= panel_pkg::tr_trig2;
        end
        panel_pkg::tr_trig2: begin
          // step the display selector once per burst that carried dsel
          if (strobes.dseld) begin
            if (dsel == 3'(panel_pkg::view_count - 1)) begin
              dsel <= '0;
            end else begin
              dsel <= dsel + 3'd1;
            end
          end
          trig_state <= panel_pkg::tr_trig3;
        end
        panel_pkg::tr_trig3: begin
          trig_state <= panel_pkg::tr_delay;
        end
        panel_pkg::tr_delay: begin
          if (trig_cnt[panel_pkg::debounce_bits]) begin
            // lockout is over
            sw_active_q <= 1'b0;
            trig_state  <= panel_pkg::tr_reenable;
          end else begin
            // the strobes drop on the first delay count, four cycles after rising
            burst       <= '0;
            sw_active_q <= 1'b1;
            trig_cnt    <= trig_cnt + 1'b1;
          end
        end
        panel_pkg::tr_reenable: begin
          // one idle cycle before the switches are watched again
          trig_state <= panel_pkg::tr_latch;
        end
        default: begin
          trig_state <= panel_pkg::tr_latch;
        end
      endcase
    end
  end

endmodule

/* hdl/panel_ram.sv */
`timescale 1ns/10ps

module panel_ram (
  input  logic                            clk,
  input  logic                            we,
  input  logic [7:0]                      addr,
  input  logic [panel_pkg::data_width-1:0] wdata,
  output logic [panel_pkg::data_width-1:0] rdata
);

  // panel memory, contents start out unknown
  logic [panel_pkg::data_width-1:0] mem [panel_pkg::ram_depth];

  // write happens on the clock edge when we is high
  always_ff @(posedge clk) begin
    if (we) begin
      mem[addr] <= wdata;
    end
  end

  // the read is registered, rdata follows addr by one cycle
  // a write to the same byte returns the old contents that cycle
  always_ff @(posedge clk) begin
    rdata <= mem[addr];
  end

endmodule

/* hdl/panel_monitor.sv */
`timescale 1ns/10ps

module panel_monitor (
  input  logic                             clk,
  input  logic                             reset,
  input  logic [7:0]                       data_sw,
  input  logic [2:0]                       dsel,
  panel_strobe_if.sink                     strobes,
  output logic [7:0]                       ram_addr,
  output logic [panel_pkg::data_width-1:0] ram_wdata,
  output logic                             ram_we,
  input  logic [panel_pkg::data_width-1:0] ram_rdata,
  output logic [panel_pkg::data_width-1:0] leds
);

  panel_pkg::mon_state_t mon_state;
  panel_pkg::panel_cmd_t cmd;
  panel_pkg::panel_cmd_t last_cmd;

  logic [panel_pkg::addr_width-1:0] addr;
  logic [panel_pkg::data_width-1:0] data_reg;
  logic [panel_pkg::data_width-1:0] wdata_q;

  logic trig_q;
  logic trig_edge;
  logic rd_wait;
  logic busy;

  // the trigger stays high for several cycles, act only on its first one
  assign trig_edge = strobes.triggerd & ~trig_q;

  // the memory only sees the low address byte
  assign ram_addr  = addr[7:0];
  assign ram_wdata = wdata_q;
  assign ram_we    = (mon_state == panel_pkg::mon_write);
  assign busy      = (mon_state != panel_pkg::mon_idle);

  // priority decode, clear wins over everything and cont is last
  always_comb begin
    if (strobes.cleard) begin
      cmd = panel_pkg::cmd_clear;
    end else if (strobes.extd_addrd) begin
      cmd = panel_pkg::cmd_extd_addr;
    end else if (strobes.addr_loadd) begin
      cmd = panel_pkg::cmd_addr_load;
    end else if (strobes.depd) begin
      cmd = panel_pkg::cmd_dep;
    end else if (strobes.examd) begin
      cmd = panel_pkg::cmd_exam;
    end else if (strobes.contd) begin
      cmd = panel_pkg::cmd_cont;
    end else begin
      cmd = panel_pkg::cmd_none;
    end
  end

  // deposit data is taken from the switches at the trigger edge
  always_ff @(posedge clk) begin
    if (trig_edge) begin
      wdata_q <= data_sw;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      trig_q    <= 1'b0;
      mon_state <= panel_pkg::mon_idle;
      rd_wait   <= 1'b0;
      addr      <= '0;
      data_reg  <= '0;
      last_cmd  <= panel_pkg::cmd_none;
    end else begin
      trig_q <= strobes.triggerd;
      case (mon_state)
        panel_pkg::mon_idle: begin
          if (trig_edge) begin
            // a burst with only dsel in it leaves the last command alone
            if (cmd != panel_pkg::cmd_none) begin
              last_cmd <= cmd;
            end
            case (cmd)
              panel_pkg::cmd_clear: begin
                addr     <= '0;
                data_reg <= '0;
              end
              panel_pkg::cmd_extd_addr: begin
                addr[panel_pkg::addr_width-1:panel_pkg::data_width] <= data_sw;
              end
              panel_pkg::cmd_addr_load: begin
                addr[panel_pkg::data_width-1:0] <= data_sw;
              end
              panel_pkg::cmd_dep: begin
                mon_state <= panel_pkg::mon_write;
              end
              panel_pkg::cmd_exam: begin
                rd_wait   <= 1'b1;
                mon_state <= panel_pkg::mon_read;
              end
              panel_pkg::cmd_cont: begin
                // step first, the read then picks up the new address
                addr      <= addr + 1'b1;
                rd_wait   <= 1'b1;
                mon_state <= panel_pkg::mon_read;
              end
              default: begin
                mon_state <= panel_pkg::mon_idle;
              end
            endcase
          end
        end
        panel_pkg::mon_read: begin
          // one cycle for the memory to register the address, then take rdata
          if (rd_wait) begin
            rd_wait <= 1'b0;
          end else begin
            data_reg  <= ram_rdata;
            mon_state <= panel_pkg::mon_idle;
          end
        end
        panel_pkg::mon_write: begin
          // ram_we is up this cycle, the address steps as the write lands
          addr      <= addr + 1'b1;
          mon_state <= panel_pkg::mon_idle;
        end
        default: begin
          mon_state <= panel_pkg::mon_idle;
        end
      endcase
    end
  end

  // led view mux, plain combinational decode of dsel
  always_comb begin
    case (panel_pkg::view_t'(dsel))
      panel_pkg::view_addr_lo:  leds = addr[panel_pkg::data_width-1:0];
      panel_pkg::view_addr_hi:  leds = addr[panel_pkg::addr_width-1:panel_pkg::data_width];
      panel_pkg::view_data:     leds = data_reg;
      panel_pkg::view_switches: leds = data_sw;
      panel_pkg::view_last_cmd: leds = {{(panel_pkg::data_width - 3){1'b0}}, last_cmd};
      // status shows the lockout in bit 0 and the sequencer busy in bit 1
      panel_pkg::view_status:   leds = {{(panel_pkg::data_width - 2){1'b0}}, busy,
                                        strobes.sw_active};
      default:                  leds = '0;
    endcase
  end

endmodule

/* hdl/panel_top.sv */
`timescale 1ns/10ps

module panel_top (
  input  logic       clk,
  input  logic       reset,
  input  logic       clear,
  input  logic       extd_addr,
  input  logic       addr_load,
  input  logic       dep,
  input  logic       exam,
  input  logic       cont,
  input  logic       dsel_sw,
  input  logic [7:0] data_sw,
  output logic [7:0] leds,
  output logic [2:0] dsel,
  output logic       sw_active
);

  // strobe bundle from the switch sequencer to the monitor
  panel_strobe_if strobe_bus ();

  // memory side wiring
  logic [7:0] ram_addr;
  logic [7:0] ram_wdata;
  logic [7:0] ram_rdata;
  logic       ram_we;

  // the lockout flag is also brought out for the panel lamp
  assign sw_active = strobe_bus.sw_active;

  front_panel front_panel_inst (
    .clk       (clk),
    .reset     (reset),
    .clear     (clear),
    .extd_addr (extd_addr),
    .addr_load (addr_load),
    .dep       (dep),
    .exam      (exam),
    .cont      (cont),
    .dsel_sw   (dsel_sw),
    .strobes   (strobe_bus.source),
    .dsel      (dsel)
  );

  panel_monitor panel_monitor_inst (
    .clk       (clk),
    .reset     (reset),
    .data_sw   (data_sw),
    .dsel      (dsel),
    .strobes   (strobe_bus.sink),
    .ram_addr  (ram_addr),
    .ram_wdata (ram_wdata),
    .ram_we    (ram_we),
    .ram_rdata (ram_rdata),
    .leds      (leds)
  );

  panel_ram panel_ram_inst (
    .clk   (clk),
    .we    (ram_we),
    .addr  (ram_addr),
    .wdata (ram_wdata),
    .rdata (ram_rdata)
  );

endmodule

/* sim/tb_panel_top.sv */
`timescale 1ns/10ps

module tb_panel_top;

  // switch sets as {clear, extd_addr, addr_load, dep, exam, cont, dsel_sw}
  localparam logic [6:0] sw_clear = 7'b1000000;
  localparam logic [6:0] sw_extd  = 7'b0100000;
  localparam logic [6:0] sw_load  = 7'b0010000;
  localparam logic [6:0] sw_dep   = 7'b0001000;
  localparam logic [6:0] sw_exam  = 7'b0000100;
  localparam logic [6:0] sw_cont  = 7'b0000010;
  localparam logic [6:0] sw_dsel  = 7'b0000001;

  localparam integer clk_half_ns  = 4;
  localparam integer n_dsel_steps = 8;
  localparam integer n_addr_loads = 4;
  localparam integer n_deps       = 8;
  localparam integer n_random     = 24;
  localparam integer n_lockout    = 3;

  // the lockout holds sw_active for 16 delay counts, one per clock
  localparam integer lockout_cycles = 16;

  // worst case press count, walking to a view can take five dsel presses
  localparam integer max_presses = 6 + n_dsel_steps + n_addr_loads * 8 + n_deps * 2 + 20 +
                                   n_random * 12 + n_lockout + 12;
  localparam integer watchdog_cycles = max_presses * 40 + 200;

  logic       clk = 1'b0;
  logic       reset;
  logic       clear;
  logic       extd_addr;
  logic       addr_load;
  logic       dep;
  logic       exam;
  logic       cont;
  logic       dsel_sw;
  logic [7:0] data_sw;
  logic [7:0] leds;
  logic [2:0] dsel;
  logic       sw_active;

  // reference model of the monitor state
  logic [panel_pkg::addr_width-1:0] m_addr;
  logic [panel_pkg::data_width-1:0] m_data;
  logic                             m_data_known;
  panel_pkg::panel_cmd_t            m_cmd;
  panel_pkg::view_t                 m_dsel;
  logic [panel_pkg::data_width-1:0] m_mem [panel_pkg::ram_depth];
  logic                             m_written [panel_pkg::ram_depth];

  integer seed;
  integer k;
  integer test_errors;
  integer test_checks;
  integer total_errors;
  integer total_checks;
  integer tests_run;
  integer tests_failed;
  integer press_count;
  logic [7:0] hi_byte;
  logic [7:0] lo_byte;
  logic [7:0] rb;
  logic [6:0] top_bit;
  logic [6:0] lower_mask;
  logic [6:0] sw_set;

  panel_top panel_top_inst (
    .clk       (clk),
    .reset     (reset),
    .clear     (clear),
    .extd_addr (extd_addr),
    .addr_load (addr_load),
    .dep       (dep),
    .exam      (exam),
    .cont      (cont),
    .dsel_sw   (dsel_sw),
    .data_sw   (data_sw),
    .leds      (leds),
    .dsel      (dsel),
    .sw_active (sw_active)
  );

  always #clk_half_ns clk = ~clk;

  function automatic logic [7:0] random_byte();
    integer r;
    r = $random(seed);
    return r[7:0];
  endfunction

  task automatic check_leds(input string name, input logic [panel_pkg::data_width-1:0] got,
                            input logic [panel_pkg::data_width-1:0] exp);
    test_checks++;
    if (got !== exp) begin
      test_errors++;
      $display("FAIL %s: got 0x%02h expected 0x%02h", name, got, exp);
    end
  endtask

  task automatic check_dsel(input panel_pkg::view_t got, input panel_pkg::view_t exp);
    test_checks++;
    if (got !== exp) begin
      test_errors++;
      $display("FAIL dsel: got 0x%0h expected 0x%0h", got, exp);
    end
  endtask

  task automatic check_cmd(input panel_pkg::panel_cmd_t got, input panel_pkg::panel_cmd_t exp);
    test_checks++;
    if (got !== exp) begin
      test_errors++;
      $display("FAIL leds last_cmd: got 0x%0h expected 0x%0h", got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    test_checks++;
    if (got !== exp) begin
      test_errors++;
      $display("FAIL %s: got 0x%0h expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic check_count(input string name, input integer got, input integer exp);
    test_checks++;
    if (got !== exp) begin
      test_errors++;
      $display("FAIL %s: got 0x%0h expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic drive_switches(input logic [6:0] sw);
    {clear, extd_addr, addr_load, dep, exam, cont, dsel_sw} = sw;
  endtask

  // outputs are sampled on the falling edge, away from the register updates
  task automatic wait_lockout(input logic level);
    do begin
      @(negedge clk);
    end while (sw_active !== level);
  endtask

  // hold a switch set until the panel locks out, then let go
  // a nonzero noise set is pressed inside the lockout and released before it ends
  task automatic press_switches(input logic [6:0] sw, input logic [7:0] data,
                                input logic [6:0] noise);
    time    rise_time;
    integer high_cycles;
    @(posedge clk);
    #1;
    drive_switches(sw);
    data_sw = data;
    wait_lockout(1'b1);
    rise_time = $time;
    @(posedge clk);
    #1;
    drive_switches(noise);
    if (noise != 7'd0) begin
      data_sw = ~data;
      repeat (6) @(posedge clk);
      #1;
      drive_switches(7'd0);
      data_sw = data;
    end
    wait_lockout(1'b0);
    // one clock period is 8 ns
    high_cycles = int'(($time - rise_time) / 8);
    check_count("sw_active high cycles", high_cycles, lockout_cycles);
  endtask

  // only the highest command of a burst runs, dsel steps on top of it
  task automatic model_apply(input logic [6:0] sw, input logic [7:0] data);
    panel_pkg::panel_cmd_t c;
    if (sw[6]) begin
      c = panel_pkg::cmd_clear;
    end else if (sw[5]) begin
      c = panel_pkg::cmd_extd_addr;
    end else if (sw[4]) begin
      c = panel_pkg::cmd_addr_load;
    end else if (sw[3]) begin
      c = panel_pkg::cmd_dep;
    end else if (sw[2]) begin
      c = panel_pkg::cmd_exam;
    end else if (sw[1]) begin
      c = panel_pkg::cmd_cont;
    end else begin
      c = panel_pkg::cmd_none;
    end
    case (c)
      panel_pkg::cmd_clear: begin
        m_addr       = '0;
        m_data       = '0;
        m_data_known = 1'b1;
      end
      panel_pkg::cmd_extd_addr: m_addr[15:8] = data;
      panel_pkg::cmd_addr_load: m_addr[7:0] = data;
      panel_pkg::cmd_dep: begin
        m_mem[m_addr[7:0]]     = data;
        m_written[m_addr[7:0]] = 1'b1;
        m_addr                 = m_addr + 16'd1;
      end
      panel_pkg::cmd_exam, panel_pkg::cmd_cont: begin
        // cont steps the address before its read
        if (c == panel_pkg::cmd_cont) begin
          m_addr = m_addr + 16'd1;
        end
        m_data       = m_mem[m_addr[7:0]];
        m_data_known = m_written[m_addr[7:0]];
      end
      default: begin
      end
    endcase
    if (c != panel_pkg::cmd_none) begin
      m_cmd = c;
    end
    if (sw[0]) begin
      if (m_dsel == panel_pkg::view_status) begin
        m_dsel = panel_pkg::view_addr_lo;
      end else begin
        m_dsel = panel_pkg::view_t'(m_dsel + 3'd1);
      end
    end
  endtask

  // compare dsel and whatever view the leds show now
  task automatic check_view();
    check_dsel(panel_pkg::view_t'(dsel), m_dsel);
    case (m_dsel)
      panel_pkg::view_addr_lo:  check_leds("leds addr_lo", leds, m_addr[7:0]);
      panel_pkg::view_addr_hi:  check_leds("leds addr_hi", leds, m_addr[15:8]);
      panel_pkg::view_data: begin
        // a read of a byte never written gives no known value
        if (m_data_known) begin
          check_leds("leds data", leds, m_data);
        end
      end
      panel_pkg::view_switches: check_leds("leds switches", leds, data_sw);
      panel_pkg::view_last_cmd: begin
        check_cmd(panel_pkg::panel_cmd_t'(leds[2:0]), m_cmd);
        check_leds("leds[7:3]", leds & 8'hf8, 8'h00);
      end
      panel_pkg::view_status:   check_leds("leds status", leds, 8'h00);
    endcase
  endtask

  task automatic step(input logic [6:0] sw, input logic [7:0] data, input logic [6:0] noise);
    press_switches(sw, data, noise);
    model_apply(sw, data);
    press_count++;
    check_view();
  endtask

  task automatic goto_view(input panel_pkg::view_t v);
    while (m_dsel != v) begin
      step(sw_dsel, data_sw, 7'd0);
    end
    check_view();
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (test_errors == 0) begin
      $display("test %0d %s: ok, %0d checks", tests_run, name, test_checks);
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d errors in %0d checks", tests_run, name, test_errors,
               test_checks);
    end
    total_errors += test_errors;
    total_checks += test_checks;
    test_errors = 0;
    test_checks = 0;
  endtask

  // the run is bounded by the worst case number of presses
  initial begin
    #(watchdog_cycles * 2 * clk_half_ns);
    $display("timeout after %0d cycles, the panel stopped responding", watchdog_cycles);
    $display("tests failed");
    $finish;
  end

  initial begin
    seed         = 32'ha125_4f6e;
    reset        = 1'b1;
    data_sw      = 8'h00;
    drive_switches(7'd0);
    test_errors  = 0;
    test_checks  = 0;
    total_errors = 0;
    total_checks = 0;
    tests_run    = 0;
    tests_failed = 0;
    press_count  = 0;
    m_addr       = '0;
    m_data       = '0;
    m_data_known = 1'b1;
    m_cmd        = panel_pkg::cmd_none;
    m_dsel       = panel_pkg::view_addr_lo;
    for (int i = 0; i < panel_pkg::ram_depth; i++) begin
      m_written[i] = 1'b0;
    end
    repeat (3) @(posedge clk);
    #1;
    reset = 1'b0;
    @(negedge clk);

    // every view reads zero out of reset, six presses bring dsel back to 0
    check_flag("sw_active", sw_active, 1'b0);
    check_view();
    repeat (panel_pkg::view_count) step(sw_dsel, 8'h00, 7'd0);
    end_test("reset_views");

    repeat (n_dsel_steps) step(sw_dsel, random_byte(), 7'd0);
    end_test("dsel_wrap");

    repeat (n_addr_loads) begin
      hi_byte = random_byte();
      lo_byte = random_byte();
      step(sw_extd, hi_byte, 7'd0);
      step(sw_load, lo_byte, 7'd0);
      goto_view(panel_pkg::view_addr_lo);
      goto_view(panel_pkg::view_addr_hi);
    end
    end_test("address_load");

    // deposit a run of bytes, then read it back with exam and cont
    hi_byte = random_byte();
    lo_byte = random_byte();
    step(sw_extd, hi_byte, 7'd0);
    step(sw_load, lo_byte, 7'd0);
    repeat (n_deps) step(sw_dep, random_byte(), 7'd0);
    goto_view(panel_pkg::view_addr_lo);
    step(sw_extd, hi_byte, 7'd0);
    step(sw_load, lo_byte, 7'd0);
    step(sw_exam, random_byte(), 7'd0);
    goto_view(panel_pkg::view_data);
    repeat (n_deps - 1) step(sw_cont, random_byte(), 7'd0);
    goto_view(panel_pkg::view_addr_lo);
    end_test("deposit_readback");

    // pick the top command evenly, then add random lower ones and maybe dsel
    repeat (n_random) begin
      k          = $unsigned($random(seed)) % 6;
      top_bit    = 7'd1 << (6 - k);
      lower_mask = (top_bit - 7'd1) & 7'h7e;
      rb         = random_byte();
      sw_set     = top_bit | (rb[6:0] & lower_mask) | {6'd0, rb[7]};
      step(sw_set, random_byte(), 7'd0);
      goto_view(panel_pkg::view_last_cmd);
      if (sw_set[6]) begin
        goto_view(panel_pkg::view_addr_lo);
        goto_view(panel_pkg::view_addr_hi);
        goto_view(panel_pkg::view_data);
      end
    end
    end_test("command_priority");

    // a nonzero address first, so an ignored clear is visible
    step(sw_extd, random_byte() | 8'h01, 7'd0);
    step(sw_load, random_byte() | 8'h01, 7'd0);
    repeat (n_lockout) begin
      rb = random_byte();
      step(sw_dsel, data_sw, rb[6:0] | sw_clear);
    end
    goto_view(panel_pkg::view_addr_lo);
    goto_view(panel_pkg::view_addr_hi);
    goto_view(panel_pkg::view_data);
    goto_view(panel_pkg::view_last_cmd);
    end_test("lockout_ignore");

    $display("summary: %0d tests, %0d with errors, %0d checks, %0d errors, %0d presses",
             tests_run, tests_failed, total_checks, total_errors, press_count);
    if (total_errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

/* src.f */
hdl/panel_pkg.sv
hdl/panel_strobe_if.sv
hdl/front_panel.sv
hdl/panel_ram.sv
hdl/panel_monitor.sv
hdl/panel_top.sv
sim/tb_panel_top.sv

/* Makefile */
# Verilator build and run of the panel testbench

VERILATOR ?= verilator
TOP       ?= tb_panel_top
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= all tests passed

.PHONY: sim clean

# build, run, and fail unless the pass line shows up in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
